// File: rvIsaPkg.sv
package rvIsaPkg;

    typedef logic [31:0] wordT;    // Data, address and instruction word
    typedef logic [4:0]  regIdxT;  // Register index
    typedef logic [6:0]  opcodeT;  // Major opcode, instr[6:0]
    typedef logic [2:0]  funct3T;  // instr[14:12]
    typedef logic [6:0]  funct7T;  // instr[31:25]

    // Major opcodes of the supported subset
    localparam opcodeT opReg    = 7'b0110011;
    localparam opcodeT opImm    = 7'b0010011;
    localparam opcodeT opLoad   = 7'b0000011;
    localparam opcodeT opStore  = 7'b0100011;
    localparam opcodeT opBranch = 7'b1100011;
    localparam opcodeT opLui    = 7'b0110111;

    // funct3 of register and immediate ALU operations
    localparam funct3T f3AddSub = 3'b000;  // ADD, SUB, ADDI
    localparam funct3T f3Sll    = 3'b001;
    localparam funct3T f3Slt    = 3'b010;
    localparam funct3T f3Sltu   = 3'b011;
    localparam funct3T f3Xor    = 3'b100;
    localparam funct3T f3SrlSra = 3'b101;  // Split by funct7
    localparam funct3T f3Or     = 3'b110;
    localparam funct3T f3And    = 3'b111;

    // funct3 of memory and branch classes
    localparam funct3T f3Word = 3'b010;  // LW and SW only
    localparam funct3T f3Beq  = 3'b000;
    localparam funct3T f3Bne  = 3'b001;

    // funct7 variants
    localparam funct7T f7Base = 7'b0000000;
    localparam funct7T f7Alt  = 7'b0100000;  // SUB, SRA, SRAI

endpackage

// File: rvCtrlPkg.sv
package rvCtrlPkg;

    typedef enum logic [2:0] {
        stFetch,
        stFetchRel,  // Wait for memAck low after the fetch
        stDecode,
        stExecute,
        stMem,
        stMemRel,    // Wait for memAck low after the data access
        stWrite,
        stHalt       // Illegal encoding, left only by reset
    } ctrlStateT;

    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluAnd   = 4'd2,
        aluOr    = 4'd3,
        aluXor   = 4'd4,
        aluSlt   = 4'd5,
        aluSltu  = 4'd6,
        aluSll   = 4'd7,
        aluSrl   = 4'd8,
        aluSra   = 4'd9,
        aluPassB = 4'd10  // LUI
    } aluOpT;

    typedef logic       srcASelT;
    typedef logic [1:0] srcBSelT;
    typedef logic       wbSelT;

    localparam srcASelT srcAReg  = 1'b0;
    localparam srcASelT srcAPc   = 1'b1;
    localparam srcBSelT srcBReg  = 2'd0;
    localparam srcBSelT srcBImm  = 2'd1;
    localparam srcBSelT srcBFour = 2'd2;  // PC increment
    localparam wbSelT   wbAlu    = 1'b0;
    localparam wbSelT   wbMem    = 1'b1;

endpackage

// File: aluUnit.sv
module aluUnit (
    input  rvIsaPkg::wordT   a,
    input  rvIsaPkg::wordT   b,
    input  rvCtrlPkg::aluOpT op,
    output rvIsaPkg::wordT   result,
    output logic             zero
);
    import rvCtrlPkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];  // RV32 shift amount

    always_comb begin
        case (op)
            aluAdd:   result = a + b;
            aluSub:   result = a - b;
            aluAnd:   result = a & b;
            aluOr:    result = a | b;
            aluXor:   result = a ^ b;
            aluSlt:   result = {31'b0, $signed(a) < $signed(b)};
            aluSltu:  result = {31'b0, a < b};
            aluSll:   result = a << shamt;
            aluSrl:   result = a >> shamt;
            aluSra:   result = $unsigned($signed(a) >>> shamt);
            aluPassB: result = b;
            default:  result = '0;
        endcase
    end

    assign zero = (result == '0);  // Equal operands under aluSub

endmodule

// File: regFile.sv
module regFile (
    input  logic             clk,
    input  rvIsaPkg::regIdxT rs1,
    input  rvIsaPkg::regIdxT rs2,
    input  rvIsaPkg::regIdxT rd,
    input  logic             we,
    input  rvIsaPkg::wordT   wd,
    output rvIsaPkg::wordT   rd1,
    output rvIsaPkg::wordT   rd2
);
    import rvIsaPkg::*;

    wordT regs [0:31];

    always_ff @(posedge clk) begin
        if (we && rd != '0)  // x0 is never written
            regs[rd] <= wd;
    end

    // Asynchronous reads, x0 forced to zero
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: immGen.sv
module immGen (
    input  rvIsaPkg::wordT instr,
    output rvIsaPkg::wordT imm
);
    import rvIsaPkg::*;

    opcodeT opcode;

    assign opcode = instr[6:0];

    always_comb begin
        case (opcode)
            opImm, opLoad: imm = {{20{instr[31]}}, instr[31:20]};
            opStore:       imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            opBranch:      imm = {{19{instr[31]}}, instr[31], instr[7],
                                  instr[30:25], instr[11:8], 1'b0};  // Byte offset
            opLui:         imm = {instr[31:12], 12'b0};
            default:       imm = '0;
        endcase
    end

endmodule

// File: rvDatapath.sv
module rvDatapath #(
    parameter rvIsaPkg::wordT resetPc = 32'h0000_0000
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               pcWrite,
    input  logic               pcBranch,
    input  logic               irWrite,
    input  logic               regWrite,
    input  logic               mdrWrite,
    input  logic               addrSelData,
    input  rvCtrlPkg::srcASelT srcASel,
    input  rvCtrlPkg::srcBSelT srcBSel,
    input  rvCtrlPkg::aluOpT   aluOp,
    input  rvCtrlPkg::wbSelT   wbSel,
    input  rvIsaPkg::wordT     memRdata,
    output rvIsaPkg::wordT     memAddr,
    output rvIsaPkg::wordT     memWdata,
    output rvIsaPkg::wordT     instr,
    output logic               aluZero
);
    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    wordT   pc;
    wordT   instrPc;    // Address of the held instruction
    wordT   ir;
    wordT   regA;
    wordT   regB;
    wordT   immReg;
    wordT   resultReg;
    wordT   mdr;
    wordT   rd1, rd2;
    wordT   immRaw;
    wordT   aluA, aluB;
    wordT   aluResult;
    wordT   wbData;
    regIdxT rs1Idx, rs2Idx, rdIdx;
    logic   operandLoad;  // High in the decode cycle

    assign rs1Idx = ir[19:15];
    assign rs2Idx = ir[24:20];
    assign rdIdx  = ir[11:7];

    regFile uRegFile (
        .clk (clk),
        .rs1 (rs1Idx),
        .rs2 (rs2Idx),
        .rd  (rdIdx),
        .we  (regWrite),
        .wd  (wbData),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    immGen uImmGen (
        .instr (ir),
        .imm   (immRaw)
    );

    aluUnit uAlu (
        .a      (aluA),
        .b      (aluB),
        .op     (aluOp),
        .result (aluResult),
        .zero   (aluZero)
    );

    always_comb begin
        aluA = (srcASel == srcAPc) ? pc : regA;
        case (srcBSel)
            srcBImm:  aluB = immReg;
            srcBFour: aluB = 32'd4;
            default:  aluB = regB;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= resetPc;
            operandLoad <= 1'b0;
        end else begin
            if (pcBranch)
                pc <= instrPc + immReg;  // PC was already advanced by 4
            else if (pcWrite)
                pc <= aluResult;
            operandLoad <= pcWrite;  // Decode follows the PC update
        end
    end

    always_ff @(posedge clk) begin
        if (irWrite) begin
            ir      <= memRdata;
            instrPc <= pc;
        end
        if (operandLoad) begin
            regA   <= rd1;
            regB   <= rd2;
            immReg <= immRaw;
        end
        if (mdrWrite)
            mdr <= memRdata;
        resultReg <= aluResult;  // Stable while the selects hold
    end

    assign wbData   = (wbSel == wbMem) ? mdr : resultReg;
    assign memAddr  = addrSelData ? resultReg : pc;
    assign memWdata = regB;  // Store data
    assign instr    = ir;

endmodule

// File: multiCycleControl.sv
module multiCycleControl (
    input  logic               clk,
    input  logic               rst,
    input  rvIsaPkg::wordT     instr,
    input  logic               aluZero,
    input  logic               memAck,
    output logic               memReq,
    output logic               memWe,
    output logic               pcWrite,
    output logic               pcBranch,
    output logic               irWrite,
    output logic               regWrite,
    output logic               mdrWrite,
    output logic               addrSelData,
    output rvCtrlPkg::srcASelT srcASel,
    output rvCtrlPkg::srcBSelT srcBSel,
    output rvCtrlPkg::aluOpT   aluOp,
    output rvCtrlPkg::wbSelT   wbSel,
    output rvIsaPkg::wordT     instrCount,
    output logic               halted,
    output logic               illegal
);
    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    ctrlStateT state;
    ctrlStateT nextState;
    opcodeT    opcode;
    funct3T    funct3;
    funct7T    funct7;
    logic      isReg, isImm, isLoad, isStore, isBranch, isLui, isAlt;
    logic      legal;
    aluOpT     instrAluOp;
    srcBSelT   instrSrcB;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign isReg    = (opcode == opReg);
    assign isImm    = (opcode == opImm);
    assign isLoad   = (opcode == opLoad);
    assign isStore  = (opcode == opStore);
    assign isBranch = (opcode == opBranch);
    assign isLui    = (opcode == opLui);
    assign isAlt    = (funct7 == f7Alt);

    always_comb begin
        case (opcode)
            opReg:   legal = (funct7 == f7Base) || (isAlt && (funct3 == f3AddSub ||
                                                              funct3 == f3SrlSra));
            opImm: begin
                if (funct3 == f3Sll)
                    legal = (funct7 == f7Base);
                else if (funct3 == f3SrlSra)
                    legal = (funct7 == f7Base) || isAlt;
                else
                    legal = 1'b1;
            end
            opLoad, opStore: legal = (funct3 == f3Word);  // Word access only
            opBranch:        legal = (funct3 == f3Beq) || (funct3 == f3Bne);
            opLui:           legal = 1'b1;
            default:         legal = 1'b0;
        endcase
    end

    always_comb begin
        instrAluOp = aluAdd;  // Loads and stores add the offset
        if (isLui) begin
            instrAluOp = aluPassB;
        end else if (isBranch) begin
            instrAluOp = aluSub;  // Compare through the zero flag
        end else if (isReg || isImm) begin
            case (funct3)
                f3AddSub: instrAluOp = (isReg && isAlt) ? aluSub : aluAdd;
                f3Sll:    instrAluOp = aluSll;
                f3Slt:    instrAluOp = aluSlt;
                f3Sltu:   instrAluOp = aluSltu;
                f3Xor:    instrAluOp = aluXor;
                f3SrlSra: instrAluOp = isAlt ? aluSra : aluSrl;
                f3Or:     instrAluOp = aluOr;
                f3And:    instrAluOp = aluAnd;
                default:  instrAluOp = aluAdd;
            endcase
        end
    end

    assign instrSrcB = (isReg || isBranch) ? srcBReg : srcBImm;

    // The instruction's selects hold from decode through writeback
    always_comb begin
        srcASel = srcAReg;
        srcBSel = instrSrcB;
        aluOp   = instrAluOp;
        if (state == stFetchRel) begin  // PC + 4
            srcASel = srcAPc;
            srcBSel = srcBFour;
            aluOp   = aluAdd;
        end
    end

    assign wbSel       = isLoad ? wbMem : wbAlu;
    assign addrSelData = (state == stMem) || (state == stMemRel);
    assign irWrite     = (state == stFetch) && memReq && memAck;
    assign pcWrite     = (state == stFetchRel) && !memAck;
    assign pcBranch    = (state == stExecute) && isBranch && (aluZero ^ (funct3 == f3Bne));
    assign mdrWrite    = (state == stMem) && memReq && memAck && isLoad;
    assign regWrite    = (state == stWrite);
    assign halted      = (state == stHalt);

    always_comb begin
        nextState = state;
        case (state)
            stFetch:    if (memReq && memAck) nextState = stFetchRel;
            stFetchRel: if (!memAck) nextState = stDecode;
            stDecode:   nextState = legal ? stExecute : stHalt;
            stExecute: begin
                if (isBranch)
                    nextState = stFetch;
                else if (isLoad || isStore)
                    nextState = stMem;
                else
                    nextState = stWrite;
            end
            stMem:      if (memReq && memAck) nextState = stMemRel;
            stMemRel:   if (!memAck) nextState = isStore ? stFetch : stWrite;
            stWrite:    nextState = stFetch;
            default:    nextState = stHalt;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= stFetch;
            memReq     <= 1'b0;
            memWe      <= 1'b0;
            instrCount <= '0;
            illegal    <= 1'b0;
        end else begin
            state  <= nextState;
            memReq <= (nextState == stFetch) || (nextState == stMem);  // Drops on the ack
            memWe  <= (nextState == stMem) && isStore;
            if (nextState == stFetch && state != stFetch)  // Retirement
                instrCount <= instrCount + 32'd1;
            if (state == stDecode && !legal)
                illegal <= 1'b1;
        end
    end

endmodule

// File: rvMultiCycle.sv
module rvMultiCycle #(
    parameter rvIsaPkg::wordT resetPc = 32'h0000_0000
) (
    input  logic           clk,
    input  logic           rst,
    output logic           memReq,
    output logic           memWe,
    output rvIsaPkg::wordT memAddr,
    output rvIsaPkg::wordT memWdata,
    input  logic           memAck,
    input  rvIsaPkg::wordT memRdata,
    output rvIsaPkg::wordT instrCount,
    output logic           halted,
    output logic           illegal
);
    import rvIsaPkg::*;
    import rvCtrlPkg::*;

    wordT    instr;
    logic    aluZero;
    logic    pcWrite, pcBranch, irWrite, regWrite, mdrWrite, addrSelData;
    srcASelT srcASel;
    srcBSelT srcBSel;
    aluOpT   aluOp;
    wbSelT   wbSel;

    multiCycleControl uControl (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .aluZero     (aluZero),
        .memAck      (memAck),
        .memReq      (memReq),
        .memWe       (memWe),
        .pcWrite     (pcWrite),
        .pcBranch    (pcBranch),
        .irWrite     (irWrite),
        .regWrite    (regWrite),
        .mdrWrite    (mdrWrite),
        .addrSelData (addrSelData),
        .srcASel     (srcASel),
        .srcBSel     (srcBSel),
        .aluOp       (aluOp),
        .wbSel       (wbSel),
        .instrCount  (instrCount),
        .halted      (halted),
        .illegal     (illegal)
    );

    rvDatapath #(
        .resetPc (resetPc)
    ) uDatapath (
        .clk         (clk),
        .rst         (rst),
        .pcWrite     (pcWrite),
        .pcBranch    (pcBranch),
        .irWrite     (irWrite),
        .regWrite    (regWrite),
        .mdrWrite    (mdrWrite),
        .addrSelData (addrSelData),
        .srcASel     (srcASel),
        .srcBSel     (srcBSel),
        .aluOp       (aluOp),
        .wbSel       (wbSel),
        .memRdata    (memRdata),
        .memAddr     (memAddr),
        .memWdata    (memWdata),
        .instr       (instr),
        .aluZero     (aluZero)
    );

endmodule

// File: rvMultiCycle_properties.sv
module rvMultiCycle_properties (
    input logic           clk,
    input logic           rst,
    input logic           memReq,
    input logic           memAck,
    input rvIsaPkg::wordT memAddr,
    input rvIsaPkg::wordT memWdata,
    input rvIsaPkg::wordT instrCount,
    input logic           halted
);
    timeunit 1ns;
    timeprecision 100ps;

    // Request held until the memory answers
    reqHoldsUntilAck: assert property (@(posedge clk) disable iff (rst)
        memReq && !memAck |=> memReq)
        else $error("memReq dropped before memAck");

    reqDropsAfterAck: assert property (@(posedge clk) disable iff (rst)
        $fell(memReq) |-> $past(memAck))
        else $error("memReq fell without a preceding memAck");

    // New request only once the previous ack is gone
    noRiseDuringAck: assert property (@(posedge clk) disable iff (rst)
        $rose(memReq) |-> !$past(memAck))
        else $error("memReq rose while memAck was still high");

    addrDataStable: assert property (@(posedge clk) disable iff (rst)
        memReq && $past(memReq) |-> $stable(memAddr) && $stable(memWdata))
        else $error("memAddr or memWdata changed during a request");

    resetValues: assert property (@(posedge clk)
        rst |=> !memReq && !halted && (instrCount == '0))
        else $error("Outputs not at reset values after reset");

    haltIsFinal: assert property (@(posedge clk) disable iff (rst)
        halted |=> halted && !memReq && $stable(instrCount))
        else $error("Core left the halt state or kept running");

endmodule

bind rvMultiCycle rvMultiCycle_properties props (
    .clk        (clk),
    .rst        (rst),
    .memReq     (memReq),
    .memAck     (memAck),
    .memAddr    (memAddr),
    .memWdata   (memWdata),
    .instrCount (instrCount),
    .halted     (halted)
);

// File: rvMultiCycle_tb.sv
module rvMultiCycle_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import rvIsaPkg::*;

    localparam int memWords      = 256;
    localparam int timeoutCycles = 20000;

    logic clk, rst, memReq, memWe, memAck, halted, illegal;
    wordT memAddr, memWdata, memRdata, instrCount;
    wordT mem [0:memWords-1];
    wordT refMem [0:memWords-1];
    wordT expAddr [$];
    wordT expData [$];
    int   progLen, slot, storeIdx, errors, checks, expRetired, waitLeft, cycles;
    logic pending;

    rvMultiCycle #(.resetPc(32'h0000_0000)) uut (
        .clk (clk), .rst (rst), .memReq (memReq), .memWe (memWe),
        .memAddr (memAddr), .memWdata (memWdata), .memAck (memAck),
        .memRdata (memRdata), .instrCount (instrCount), .halted (halted),
        .illegal (illegal)
    );

    always #10 clk = ~clk;

    function automatic wordT rType(input funct7T f7, input int rs2, input int rs1,
                                   input funct3T f3, input int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], opReg};
    endfunction

    function automatic wordT iType(input int imm, input int rs1, input funct3T f3,
                                   input int rd, input opcodeT op);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic wordT sType(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3Word, imm[4:0], opStore};
    endfunction

    function automatic wordT bType(input int imm, input int rs2, input int rs1,
                                   input funct3T f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], opBranch};
    endfunction

    function automatic wordT aluRef(input funct3T f3, input logic alt, input wordT a,
                                    input wordT b);
        wordT r;
        case (f3)
            3'd0:    r = alt ? a - b : a + b;
            3'd1:    r = a << b[4:0];
            3'd2:    r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    r = (a < b) ? 32'd1 : 32'd0;
            3'd4:    r = a ^ b;
            3'd5:    r = alt ? wordT'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    task automatic emit(input wordT w);
        mem[progLen] = w;
        progLen++;
    endtask

    task automatic storeReg(input int r);  // SW r, slot(x10)
        emit(sType(slot * 4, r, 10));
        slot++;
    endtask

    task automatic opAndStore(input wordT w);
        emit(w);
        storeReg(5);
    endtask

    task automatic buildProgram();
        progLen = 0;
        slot    = 0;
        emit(iType(-7, 0, f3AddSub, 1, opImm));
        emit(iType(5, 0, f3AddSub, 2, opImm));
        emit(iType(31, 0, f3AddSub, 3, opImm));
        emit({20'h80000, 5'd4, opLui});            // x4 = 0x80000000
        emit(iType(32'h200, 0, f3AddSub, 10, opImm));  // Store base
        opAndStore(rType(f7Base, 2, 1, f3AddSub, 5));
        opAndStore(rType(f7Alt, 2, 1, f3AddSub, 5));
        opAndStore(rType(f7Base, 2, 1, f3And, 5));
        opAndStore(rType(f7Base, 2, 1, f3Or, 5));
        opAndStore(rType(f7Base, 2, 1, f3Xor, 5));
        opAndStore(rType(f7Base, 2, 1, f3Slt, 5));
        opAndStore(rType(f7Base, 2, 1, f3Sltu, 5));
        opAndStore(rType(f7Base, 3, 1, f3Sll, 5));
        opAndStore(rType(f7Base, 3, 4, f3SrlSra, 5));
        opAndStore(rType(f7Alt, 3, 4, f3SrlSra, 5));
        opAndStore(iType(-100, 1, f3AddSub, 5, opImm));
        opAndStore(iType(32'h0F0, 1, f3And, 5, opImm));
        opAndStore(iType(32'h123, 1, f3Or, 5, opImm));
        opAndStore(iType(-1, 1, f3Xor, 5, opImm));
        opAndStore(iType(3, 1, f3Slt, 5, opImm));
        opAndStore(iType(-1, 1, f3Sltu, 5, opImm));
        opAndStore(iType(31, 1, f3Sll, 5, opImm));
        opAndStore(iType(31, 4, f3SrlSra, 5, opImm));
        opAndStore(iType(32'h41F, 4, f3SrlSra, 5, opImm));  // SRAI by 31
        emit(iType(32'h300, 0, f3Word, 6, opLoad));
        storeReg(6);
        emit(iType(55, 0, f3AddSub, 0, opImm));  // Write to x0 is dropped
        storeReg(0);
        emit(iType(0, 0, f3AddSub, 7, opImm));
        emit(iType(5, 0, f3AddSub, 8, opImm));
        emit(iType(1, 7, f3AddSub, 7, opImm));   // Loop body
        emit(bType(-4, 8, 7, f3Bne));
        storeReg(7);
        emit(bType(8, 0, 7, f3Beq));             // Not taken
        emit(iType(32'h5A, 0, f3AddSub, 9, opImm));
        storeReg(9);
        emit(32'h0000_0000);                     // Illegal, ends the run
    endtask

    task automatic runReference();
        wordT x [0:31];
        wordT pc, nextPc, ins, a, b, immI, immS, immB, t;
        logic done;
        for (int i = 0; i < 32; i++)
            x[i] = '0;
        pc         = '0;
        done       = 1'b0;
        expRetired = 0;
        for (int steps = 0; steps < 10000 && !done; steps++) begin
            ins    = refMem[pc[9:2]];
            a      = x[ins[19:15]];
            b      = x[ins[24:20]];
            immI   = {{20{ins[31]}}, ins[31:20]};
            immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            immB   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            nextPc = pc + 32'd4;
            case (ins[6:0])
                opReg:   x[ins[11:7]] = aluRef(ins[14:12], ins[30], a, b);
                opImm:   x[ins[11:7]] = aluRef(ins[14:12], ins[30] && ins[14:12] == 3'd5,
                                               a, immI);
                opLoad: begin
                    t = a + immI;
                    x[ins[11:7]] = refMem[t[9:2]];
                end
                opStore: begin
                    t = a + immS;
                    expAddr.push_back(t);
                    expData.push_back(b);
                    refMem[t[9:2]] = b;
                end
                opBranch: if ((a == b) != ins[12]) nextPc = pc + immB;
                opLui:   x[ins[11:7]] = {ins[31:12], 12'b0};
                default: done = 1'b1;
            endcase
            x[0] = '0;
            if (!done)
                expRetired++;
            pc = nextPc;
        end
    endtask

    task automatic checkStore();
        checks++;
        if (storeIdx >= expAddr.size()) begin
            errors++;
            $display("Unexpected store to %h after all %0d expected stores", memAddr,
                     expAddr.size());
        end else begin
            assert (memAddr == expAddr[storeIdx]) else begin
                errors++;
                $display("ERROR memAddr: got %h, expected %h", memAddr, expAddr[storeIdx]);
            end
            assert (memWdata == expData[storeIdx]) else begin
                errors++;
                $display("ERROR memWdata: got %h, expected %h", memWdata, expData[storeIdx]);
            end
        end
        storeIdx++;
    endtask

    // True once the random delay of 0 to 3 cycles has run out
    function automatic logic delayElapsed();
        if (!pending) begin
            pending  = 1'b1;
            waitLeft = $urandom % 4;
        end
        if (waitLeft == 0) begin
            pending = 1'b0;
            return 1'b1;
        end
        waitLeft--;
        return 1'b0;
    endfunction

    // Memory with a random delay of 0 to 3 cycles on the ack and on its release
    always begin
        @(posedge clk);
        #1;
        if (rst) begin
            memAck  = 1'b0;
            pending = 1'b0;
        end else if (memAck) begin
            if (!memReq) begin
                if (delayElapsed())
                    memAck = 1'b0;
            end
        end else if (memReq) begin
            if (delayElapsed()) begin
                if (memWe) begin
                    $display("Write %h to %h", memWdata, memAddr);
                    checkStore();
                    mem[memAddr[9:2]] = memWdata;
                end else begin
                    memRdata = mem[memAddr[9:2]];
                end
                memAck = 1'b1;
            end
        end
    end

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        memAck   = 1'b0;
        memRdata = '0;
        pending  = 1'b0;
        waitLeft = 0;
        errors   = 0;
        checks   = 0;
        storeIdx = 0;
        void'($urandom(32'h8493));
        for (int i = 0; i < memWords; i++)
            mem[i] = 32'hC0DE_0000 | wordT'(i);
        mem[192] = 32'hDEAD_BEEF;  // Word read by the LW
        buildProgram();
        for (int i = 0; i < memWords; i++)
            refMem[i] = mem[i];
        runReference();
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
        cycles = 0;
        while (!halted && cycles < timeoutCycles) begin
            @(posedge clk);
            cycles++;
        end
        if (!halted) begin
            errors++;
            $display("Timeout: the core did not halt within %0d cycles", timeoutCycles);
        end else begin
            repeat (5) @(posedge clk);  // Halt must stay steady
            checks += 3;
            assert (illegal) else begin
                errors++;
                $display("ERROR illegal: got %h, expected %h", illegal, 1'b1);
            end
            assert (instrCount == wordT'(expRetired)) else begin
                errors++;
                $display("ERROR instrCount: got %h, expected %h", instrCount, expRetired);
            end
            assert (storeIdx == expAddr.size()) else begin
                errors++;
                $display("ERROR storeCount: got %h, expected %h", storeIdx, expAddr.size());
            end
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: rvMultiCycle.f
rvIsaPkg.sv
rvCtrlPkg.sv
aluUnit.sv
regFile.sv
immGen.sv
rvDatapath.sv
multiCycleControl.sv
rvMultiCycle.sv
rvMultiCycle_properties.sv
rvMultiCycle_tb.sv

// File: runSim.sh
#!/bin/sh
verilator --binary --timing --assert -f rvMultiCycle.f --top-module rvMultiCycle_tb \
    -o simv > build.log 2>&1 \
    && ./obj_dir/simv > sim.log 2>&1 \
    || { echo "Build or simulation run failed"; exit 1; }
grep -q "Simulation PASSED" sim.log && echo "Test passed" || { echo "Test failed"; exit 1; }
